//--- testbench/icache_golden.txt
# op addr id expected_word refill   (all hex)
# op 0 enable, 1 disable, 2 flush, 3 fetch, 4 fetch pair addr and addr+4 with ids id, id+1
0 00000000 0 00000000 0
3 00001000 1 a5a51000 1
3 00001004 2 a5a51004 0
3 0000100c 3 a5a5100c 0
4 00001000 4 a5a51000 0
4 00001008 6 a5a51008 0
# Same index, different tag
3 00002008 8 a5a52008 1
3 00001008 9 a5a51008 1
3 00002000 a a5a52000 1
3 00001004 b a5a51004 1
# Other rows
3 00001010 c a5a51010 1
3 00001014 d a5a51014 0
3 12345670 e b7915670 1
3 12345674 f b7915674 0
4 12345670 0 b7915670 0
3 000013f0 2 a5a513f0 1
3 000013fc 3 a5a513fc 0
# Flush drops every line
2 00000000 0 00000000 0
3 00001014 4 a5a51014 1
3 12345674 5 b7915674 1
3 00001010 6 a5a51010 0
1 00001000 0 00000000 0
0 00000000 0 00000000 0
3 00001000 7 a5a51000 1
4 00001000 8 a5a51000 0
1 00002000 0 00000000 0

//--- src.f
rtl/icache_pkg.sv
rtl/icache_lookup.sv
rtl/icache_arrays.sv
rtl/icache_ctrl.sv
rtl/icache_response.sv
rtl/icache_top.sv
testbench/tb_icache.sv

//--- Bender.yml
package:
  name: icache

sources:
  - rtl/icache_pkg.sv
  - rtl/icache_lookup.sv
  - rtl/icache_arrays.sv
  - rtl/icache_ctrl.sv
  - rtl/icache_response.sv
  - rtl/icache_top.sv
  - target: simulation
    files:
      - testbench/tb_icache.sv

//--- testbench/tb_icache.sv
/* Golden-file driven fetches and control requests for the instruction cache,
   line memory responder with random delays, response checks and watchdog */

module tb_icache;
  import icache_pkg::*;

  localparam int PERIOD = 40;

  logic  clk, rst_n;
  logic  fetch_req, fetch_grant, fetch_r_valid;
  addr_t fetch_addr, init_araddr;
  id_t   fetch_id, fetch_r_id;
  data_t fetch_r_rdata;
  logic  init_arvalid, init_arready, init_rvalid, init_rready;
  line_t init_rdata;
  logic  req_enable, req_disable, req_flush;
  logic  ack_enable, ack_disable, ack_flush, pending;

  logic [31:0] ops [$];                     // Golden columns held in parallel queues
  addr_t       addrs [$];
  id_t         ids [$];
  data_t       exps [$];
  logic [31:0] refills [$];
  data_t       rsp_data [$];
  id_t         rsp_id [$];
  int          errors, tests, passed, reads, ack_en_cnt, ack_fl_cnt;
  logic        pend_exp;
  addr_t       last_araddr;
  logic [31:0] lfsr;
  bit          loaded;

  icache_top dut0 (
    .clk, .rst_n,
    .fetch_req_i (fetch_req), .fetch_addr_i (fetch_addr), .fetch_id_i (fetch_id),
    .fetch_grant_o (fetch_grant), .fetch_r_valid_o (fetch_r_valid),
    .fetch_r_rdata_o (fetch_r_rdata), .fetch_r_id_o (fetch_r_id),
    .init_arvalid_o (init_arvalid), .init_araddr_o (init_araddr),
    .init_arready_i (init_arready), .init_rvalid_i (init_rvalid),
    .init_rdata_i (init_rdata), .init_rready_o (init_rready),
    .ctrl_req_enable_i (req_enable), .ctrl_req_disable_i (req_disable),
    .ctrl_req_flush_i (req_flush), .ctrl_ack_enable_o (ack_enable),
    .ctrl_ack_disable_o (ack_disable), .ctrl_ack_flush_o (ack_flush),
    .ctrl_pending_o (pending)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic data_t mem_word(input addr_t a);
    return a ^ 32'ha5a5_0000;
  endfunction

  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic int random_delay();
    int d;
    d = 0;
    for (int i = 0; i < 3; i++) d = (d << 1) | lfsr_bit();
    return d;
  endfunction

  function automatic string op_name(input logic [31:0] op);
    case (op)
      0: return "enable";
      1: return "disable";
      2: return "flush";
      3: return "fetch";
      default: return "fetch pair";
    endcase
  endfunction

  // Memory responder answering one line per address
  initial begin
    addr_t a;
    init_arready = 1'b0;
    init_rvalid  = 1'b0;
    init_rdata   = '0;
    lfsr         = 32'hd5b9_c36c;
    forever begin
      @(negedge clk);
      if (init_arvalid) begin
        a = init_araddr;
        repeat (random_delay()) @(posedge clk);
        @(posedge clk);
        #1 init_arready = 1'b1;
        @(posedge clk);
        #1 init_arready = 1'b0;
        repeat (random_delay()) @(posedge clk);
        #1;
        for (int k = 0; k < LINE_WORDS; k++) begin
          init_rdata[k*DATA_WIDTH +: DATA_WIDTH] = mem_word(a + 4 * k);
        end
        init_rvalid = 1'b1;
        do @(negedge clk); while (!init_rready);
        @(posedge clk);
        #1 init_rvalid = 1'b0;
      end
    end
  end

  // Monitor for responses, read requests, acks and the pending flag
  initial begin
    pend_exp = 1'b0;
    forever begin
      @(negedge clk);
      if (fetch_r_valid) begin
        rsp_data.push_back(fetch_r_rdata);
        rsp_id.push_back(fetch_r_id);
      end
      if (ack_enable) ack_en_cnt++;
      if (ack_flush) ack_fl_cnt++;
      if (rst_n && pending !== pend_exp) begin
        $display("FAIL ctrl_pending_o got %h expected %h", pending, pend_exp);
        errors++;
      end
      if (init_arvalid && init_arready) begin
        reads++;
        last_araddr = init_araddr;
        pend_exp    = 1'b1;
      end
      if (init_rvalid && init_rready) pend_exp = 1'b0;
    end
  end

  // --------------------------------------------------
  // Operations
  // --------------------------------------------------
  task automatic issue(input addr_t a, input id_t id);
    fetch_req  = 1'b1;
    fetch_addr = a;
    fetch_id   = id;
    do @(negedge clk); while (!fetch_grant);
    @(posedge clk);
    #1;
  endtask

  task automatic fetch_and_compare(input int n, input addr_t a, input id_t id,
                                   input data_t exp, input logic [31:0] refill);
    int reads0;
    data_t e;
    reads0 = reads;
    rsp_data.delete();
    rsp_id.delete();
    for (int i = 0; i < n; i++) issue(a + 4 * i, id + i);
    fetch_req = 1'b0;
    while (rsp_data.size() < n) @(negedge clk);
    repeat (2) @(negedge clk);
    if (rsp_data.size() != n) begin
      $display("Extra fetch responses appeared");
      errors++;
    end
    for (int i = 0; i < n; i++) begin
      e = (i == 0) ? exp : mem_word(a + 4 * i);
      if (rsp_data[i] !== e) begin
        $display("FAIL fetch_r_rdata_o got %h expected %h", rsp_data[i], e);
        errors++;
      end
      if (rsp_id[i] !== id_t'(id + i)) begin
        $display("FAIL fetch_r_id_o got %h expected %h", rsp_id[i], id_t'(id + i));
        errors++;
      end
    end
    if (reads - reads0 != refill) begin
      $display("FAIL read requests got %h expected %h", reads - reads0, refill);
      errors++;
    end else if (refill != 0 && last_araddr !== (a & ~addr_t'(32'hf))) begin
      $display("FAIL init_araddr_o got %h expected %h", last_araddr, a & ~addr_t'(32'hf));
      errors++;
    end
  endtask

  task automatic sweep_until_ack(input logic flush);
    int cnt0;
    cnt0 = flush ? ack_fl_cnt : ack_en_cnt;
    if (flush) req_flush = 1'b1;
    else req_enable = 1'b1;
    do @(negedge clk); while (!(flush ? ack_flush : ack_enable));
    @(posedge clk);
    #1;
    req_flush  = 1'b0;
    req_enable = 1'b0;
    repeat (3) @(negedge clk);
    if ((flush ? ack_fl_cnt : ack_en_cnt) != cnt0 + 1) begin
      $display("Acknowledge did not pulse exactly once");
      errors++;
    end
  endtask

  task automatic disable_and_hold(input addr_t a);
    req_disable = 1'b1;
    do @(negedge clk); while (!ack_disable);
    @(posedge clk);
    #1;
    req_disable = 1'b0;
    fetch_req   = 1'b1;
    fetch_addr  = a;
    repeat (4) begin
      @(negedge clk);
      if (fetch_grant !== 1'b0 || ack_disable !== 1'b1) begin
        $display("FAIL fetch_grant_o %h ctrl_ack_disable_o %h while disabled",
                 fetch_grant, ack_disable);
        errors++;
      end
    end
    @(posedge clk);
    #1 fetch_req = 1'b0;
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int fd, e0;
    string line;
    logic [31:0] op, a, id, ex, rf;
    rst_n = 1'b0;
    fetch_req = 1'b0;
    fetch_addr = '0;
    fetch_id = '0;
    req_enable = 1'b0;
    req_disable = 1'b0;
    req_flush = 1'b0;
    fd = $fopen("testbench/icache_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file");
      $display("Errors found");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#" &&
            $sscanf(line, "%h %h %h %h %h", op, a, id, ex, rf) == 5) begin
          ops.push_back(op);
          addrs.push_back(a);
          ids.push_back(id);
          exps.push_back(ex);
          refills.push_back(rf);
        end
      end
      $fclose(fd);
      loaded = 1'b1;
      repeat (5) @(posedge clk);
      #1 rst_n = 1'b1;

      // Idle state after reset
      e0 = errors;
      repeat (5) begin
        @(negedge clk);
        if (fetch_grant || fetch_r_valid || init_arvalid || init_rready) begin
          $display("FAIL fetch_grant_o %h fetch_r_valid_o %h init_arvalid_o %h init_rready_o %h",
                   fetch_grant, fetch_r_valid, init_arvalid, init_rready);
          errors++;
        end
        if (!ack_disable || ack_enable || ack_flush) begin
          $display("FAIL ctrl_ack_disable_o %h ctrl_ack_enable_o %h ctrl_ack_flush_o %h",
                   ack_disable, ack_enable, ack_flush);
          errors++;
        end
      end
      tests++;
      if (errors == e0) passed++;
      $display("test 0 reset: %s", (errors == e0) ? "PASS" : "FAIL");

      foreach (ops[i]) begin
        e0 = errors;
        @(posedge clk);
        #1;
        case (ops[i])
          0: sweep_until_ack(1'b0);
          1: disable_and_hold(addrs[i]);
          2: sweep_until_ack(1'b1);
          3: fetch_and_compare(1, addrs[i], ids[i], exps[i], refills[i]);
          default: fetch_and_compare(2, addrs[i], ids[i], exps[i], refills[i]);
        endcase
        tests++;
        if (errors == e0) passed++;
        $display("test %0d %s %h: %s", i + 1, op_name(ops[i]), addrs[i],
                 (errors == e0) ? "PASS" : "FAIL");
      end

      $display("%0d tests, %0d passed, %0d errors", tests, passed, errors);
      if (errors == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
      $finish;
    end
  end

  // Watchdog scaled by the number of golden lines
  initial begin
    wait (loaded);
    #((ops.size() + 1) * (N_ROWS + 40) * PERIOD);
    $display("Run timed out waiting for the DUT");
    $display("Errors found");
    $finish;
  end

endmodule

//--- rtl/icache_top.sv
/* Instruction cache top: lookup, arrays, controller and response */

module icache_top (
  input  logic                clk,
  input  logic                rst_n,

  // Fetch port
  input  logic                fetch_req_i,
  input  icache_pkg::addr_t   fetch_addr_i,
  input  icache_pkg::id_t     fetch_id_i,
  output logic                fetch_grant_o,
  output logic                fetch_r_valid_o,
  output icache_pkg::data_t   fetch_r_rdata_o,
  output icache_pkg::id_t     fetch_r_id_o,

  // Memory read port
  output logic                init_arvalid_o,
  output icache_pkg::addr_t   init_araddr_o,
  input  logic                init_arready_i,
  input  logic                init_rvalid_i,
  input  icache_pkg::line_t   init_rdata_i,
  output logic                init_rready_o,

  // Control
  input  logic                ctrl_req_enable_i,
  input  logic                ctrl_req_disable_i,
  input  logic                ctrl_req_flush_i,
  output logic                ctrl_ack_enable_o,
  output logic                ctrl_ack_disable_o,
  output logic                ctrl_ack_flush_o,
  output logic                ctrl_pending_o
);
  import icache_pkg::*;

  // --------------------------------------------------
  // Internal wires
  // --------------------------------------------------
  index_t     rd_index;
  logic       s1_req, s1_hit;
  id_t        s1_id;
  index_t     s1_index;
  tag_t       s1_tag;
  word_sel_t  s1_word;
  logic       advance, clear;
  logic       rd_en, wr_en;
  index_t     wr_index;
  tag_entry_t wr_tag, tag_entry;
  line_t      line;
  logic       hit_resp, refill_resp;
  id_t        refill_id;
  word_sel_t  refill_word;

  icache_lookup u_lookup (
    .clk, .rst_n, .fetch_req_i, .fetch_addr_i, .fetch_id_i,
    .advance_i   (advance),
    .clear_i     (clear),
    .tag_entry_i (tag_entry),
    .rd_index_o  (rd_index),
    .s1_req_o    (s1_req),
    .s1_id_o     (s1_id),
    .s1_index_o  (s1_index),
    .s1_tag_o    (s1_tag),
    .s1_word_o   (s1_word),
    .s1_hit_o    (s1_hit)
  );

  icache_arrays u_arrays (
    .clk, .rst_n,
    .rd_en_i     (rd_en),
    .rd_index_i  (rd_index),
    .wr_en_i     (wr_en),
    .wr_index_i  (wr_index),
    .wr_tag_i    (wr_tag),
    .wr_line_i   (init_rdata_i),  // Refill line goes in as it arrives
    .tag_entry_o (tag_entry),
    .line_o      (line)
  );

  icache_ctrl u_ctrl (
    .clk, .rst_n, .fetch_req_i, .fetch_grant_o,
    .s1_req_i (s1_req), .s1_hit_i (s1_hit), .s1_id_i (s1_id),
    .s1_index_i (s1_index), .s1_tag_i (s1_tag), .s1_word_i (s1_word),
    .advance_o (advance), .clear_o (clear),
    .rd_en_o (rd_en), .wr_en_o (wr_en), .wr_index_o (wr_index), .wr_tag_o (wr_tag),
    .init_arvalid_o, .init_araddr_o, .init_arready_i, .init_rvalid_i, .init_rready_o,
    .hit_resp_o (hit_resp), .refill_resp_o (refill_resp),
    .refill_id_o (refill_id), .refill_word_o (refill_word),
    .ctrl_req_enable_i, .ctrl_req_disable_i, .ctrl_req_flush_i,
    .ctrl_ack_enable_o, .ctrl_ack_disable_o, .ctrl_ack_flush_o, .ctrl_pending_o
  );

  icache_response u_response (
    .clk, .rst_n,
    .hit_resp_i    (hit_resp),
    .refill_resp_i (refill_resp),
    .s1_id_i       (s1_id),
    .s1_word_i     (s1_word),
    .refill_id_i   (refill_id),
    .refill_word_i (refill_word),
    .line_i        (line),
    .init_rdata_i, .fetch_r_valid_o, .fetch_r_rdata_o, .fetch_r_id_o
  );

endmodule

//--- rtl/icache_response.sv
/* Word selection for hits and refills, registered fetch response */

module icache_response (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  hit_resp_i,
  input  logic                  refill_resp_i,
  input  icache_pkg::id_t       s1_id_i,
  input  icache_pkg::word_sel_t s1_word_i,
  input  icache_pkg::id_t       refill_id_i,
  input  icache_pkg::word_sel_t refill_word_i,
  input  icache_pkg::line_t     line_i,
  input  icache_pkg::line_t     init_rdata_i,

  output logic                  fetch_r_valid_o,
  output icache_pkg::data_t     fetch_r_rdata_o,
  output icache_pkg::id_t       fetch_r_id_o
);
  import icache_pkg::*;

  function automatic data_t pick_word(input line_t line, input word_sel_t sel);
    pick_word = line[sel * DATA_WIDTH +: DATA_WIDTH];
  endfunction

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      fetch_r_valid_o <= 1'b0;
    end else begin
      fetch_r_valid_o <= hit_resp_i | refill_resp_i;  // One cycle per strobe
    end
  end

  always_ff @(posedge clk) begin
    if (refill_resp_i) begin
      fetch_r_rdata_o <= pick_word(init_rdata_i, refill_word_i);  // Straight from memory
      fetch_r_id_o    <= refill_id_i;
    end else if (hit_resp_i) begin
      fetch_r_rdata_o <= pick_word(line_i, s1_word_i);
      fetch_r_id_o    <= s1_id_i;
    end
  end

endmodule

//--- rtl/icache_ctrl.sv
/* Cache controller FSM: enable, disable, flush sweep, grant, refill request
   and array writes */

module icache_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,

  // Fetch side
  input  logic                   fetch_req_i,
  output logic                   fetch_grant_o,

  // Stage 1 from the lookup
  input  logic                   s1_req_i,
  input  logic                   s1_hit_i,
  input  icache_pkg::id_t        s1_id_i,
  input  icache_pkg::index_t     s1_index_i,
  input  icache_pkg::tag_t       s1_tag_i,
  input  icache_pkg::word_sel_t  s1_word_i,
  output logic                   advance_o,
  output logic                   clear_o,

  // Arrays
  output logic                   rd_en_o,
  output logic                   wr_en_o,
  output icache_pkg::index_t     wr_index_o,
  output icache_pkg::tag_entry_t wr_tag_o,

  // Memory read port
  output logic                   init_arvalid_o,
  output icache_pkg::addr_t      init_araddr_o,
  input  logic                   init_arready_i,
  input  logic                   init_rvalid_i,
  output logic                   init_rready_o,

  // Response strobes
  output logic                   hit_resp_o,
  output logic                   refill_resp_o,
  output icache_pkg::id_t        refill_id_o,
  output icache_pkg::word_sel_t  refill_word_o,

  // Control side
  input  logic                   ctrl_req_enable_i,
  input  logic                   ctrl_req_disable_i,
  input  logic                   ctrl_req_flush_i,
  output logic                   ctrl_ack_enable_o,
  output logic                   ctrl_ack_disable_o,
  output logic                   ctrl_ack_flush_o,
  output logic                   ctrl_pending_o
);
  import icache_pkg::*;

  ctrl_state_t state_q, state_d;
  index_t      row_q;                  // Sweep row counter
  logic        flush_q, flush_d;       // Sweep was started by a flush
  logic        to_dis_q, to_dis_d;     // Sweep returns to DISABLED
  logic        last_row;
  logic        capture;

  // Details of the one refill in flight
  id_t         refill_id_q;
  index_t      refill_index_q;
  tag_t        refill_tag_q;
  word_sel_t   refill_word_q;

  // --------------------------------------------------
  // State and sweep registers
  // --------------------------------------------------
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= DISABLED;
      row_q    <= '0;
      flush_q  <= 1'b0;
      to_dis_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      flush_q  <= flush_d;
      to_dis_q <= to_dis_d;
      if (state_q == INVALIDATE) begin
        row_q <= row_q + 1'b1;  // Wraps to zero after the last row
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      refill_id_q    <= s1_id_i;
      refill_index_q <= s1_index_i;
      refill_tag_q   <= s1_tag_i;
      refill_word_q  <= s1_word_i;
    end
  end

  assign last_row = (row_q == index_t'(N_ROWS - 1));

  // --------------------------------------------------
  // Next state and outputs
  // --------------------------------------------------
  always_comb begin
    state_d           = state_q;
    flush_d           = flush_q;
    to_dis_d          = to_dis_q;
    fetch_grant_o     = 1'b0;
    advance_o         = 1'b0;
    clear_o           = 1'b0;
    capture           = 1'b0;
    wr_en_o           = 1'b0;
    wr_index_o        = row_q;
    wr_tag_o          = '0;          // Valid bit cleared
    init_arvalid_o    = 1'b0;
    init_rready_o     = 1'b0;
    hit_resp_o        = 1'b0;
    refill_resp_o     = 1'b0;
    ctrl_ack_enable_o = 1'b0;
    ctrl_ack_flush_o  = 1'b0;

    unique case (state_q)
      DISABLED: begin
        if (ctrl_req_enable_i) begin
          state_d  = INVALIDATE;
          flush_d  = 1'b0;
          to_dis_d = 1'b0;
        end else if (ctrl_req_flush_i) begin
          state_d  = INVALIDATE;     // Flush while off, stay off afterwards
          flush_d  = 1'b1;
          to_dis_d = 1'b1;
        end
      end

      INVALIDATE: begin
        wr_en_o = 1'b1;
        if (last_row) begin
          ctrl_ack_flush_o  = flush_q;
          ctrl_ack_enable_o = !flush_q;
          state_d           = to_dis_q ? DISABLED : OPERATIVE;
        end
      end

      OPERATIVE: begin
        if (s1_req_i && !s1_hit_i) begin
          // Miss: hold its details and empty the pipe
          clear_o = 1'b1;
          capture = 1'b1;
          state_d = REFILL_REQ;
        end else begin
          hit_resp_o = s1_req_i;
          if (ctrl_req_disable_i) begin
            clear_o = 1'b1;
            state_d = DISABLED;
          end else if (ctrl_req_flush_i || ctrl_req_enable_i) begin
            clear_o  = 1'b1;
            state_d  = INVALIDATE;
            flush_d  = ctrl_req_flush_i;
            to_dis_d = 1'b0;
          end else begin
            fetch_grant_o = 1'b1;
            advance_o     = 1'b1;
          end
        end
      end

      REFILL_REQ: begin
        init_arvalid_o = 1'b1;
        if (init_arready_i) begin
          state_d = REFILL_WAIT;
        end
      end

      REFILL_WAIT: begin
        init_rready_o = 1'b1;
        wr_index_o    = refill_index_q;
        wr_tag_o      = {1'b1, refill_tag_q};
        if (init_rvalid_i) begin
          wr_en_o       = 1'b1;  // Line written as it is returned
          refill_resp_o = 1'b1;
          state_d       = DISPATCH;
        end
      end

      DISPATCH: begin
        state_d = OPERATIVE;
      end

      default: begin
        state_d = DISABLED;
      end
    endcase
  end

  assign rd_en_o            = fetch_req_i & fetch_grant_o;
  assign init_araddr_o      = {refill_tag_q, refill_index_q,
                               {(WORD_SEL_BITS + OFFSET_BITS){1'b0}}};  // Line aligned
  assign refill_id_o        = refill_id_q;
  assign refill_word_o      = refill_word_q;
  assign ctrl_ack_disable_o = (state_q == DISABLED);
  assign ctrl_pending_o     = (state_q == REFILL_WAIT);

endmodule

//--- rtl/icache_arrays.sv
/* Direct-mapped tag and line storage with registered read */

module icache_arrays (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   rd_en_i,
  input  icache_pkg::index_t     rd_index_i,

  input  logic                   wr_en_i,
  input  icache_pkg::index_t     wr_index_i,
  input  icache_pkg::tag_entry_t wr_tag_i,
  input  icache_pkg::line_t      wr_line_i,

  output icache_pkg::tag_entry_t tag_entry_o,
  output icache_pkg::line_t      line_o
);
  import icache_pkg::*;

  tag_entry_t tag_mem  [N_ROWS];
  line_t      line_mem [N_ROWS];
  logic       line_we;

  // Only a valid tag comes with a line, sweep writes touch the tags alone
  assign line_we = wr_en_i & wr_tag_i[TAG_BITS];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      tag_mem[wr_index_i] <= wr_tag_i;
    end
    if (line_we) begin
      line_mem[wr_index_i] <= wr_line_i;
    end
    if (rd_en_i) begin
      line_o <= line_mem[rd_index_i];
    end
  end

  // Read port for the tags, comes up invalid
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      tag_entry_o <= '0;
    end else if (rd_en_i) begin
      tag_entry_o <= tag_mem[rd_index_i];
    end
  end

endmodule

//--- rtl/icache_lookup.sv
/* Fetch address split, stage-1 pipeline register and tag compare */

module icache_lookup (
  input  logic                   clk,
  input  logic                   rst_n,

  // Incoming fetch
  input  logic                   fetch_req_i,
  input  icache_pkg::addr_t      fetch_addr_i,
  input  icache_pkg::id_t        fetch_id_i,

  // Pipeline strobes from the controller
  input  logic                   advance_i,
  input  logic                   clear_i,

  // Tag array
  input  icache_pkg::tag_entry_t tag_entry_i,
  output icache_pkg::index_t     rd_index_o,

  // Stage 1
  output logic                   s1_req_o,
  output icache_pkg::id_t        s1_id_o,
  output icache_pkg::index_t     s1_index_o,
  output icache_pkg::tag_t       s1_tag_o,
  output icache_pkg::word_sel_t  s1_word_o,
  output logic                   s1_hit_o
);
  import icache_pkg::*;

  word_sel_t in_word;
  index_t    in_index;
  tag_t      in_tag;

  // --------------------------------------------------
  // Address split of the incoming fetch
  // --------------------------------------------------
  assign in_word  = fetch_addr_i[OFFSET_BITS +: WORD_SEL_BITS];
  assign in_index = fetch_addr_i[OFFSET_BITS + WORD_SEL_BITS +: INDEX_BITS];
  assign in_tag   = fetch_addr_i[ADDR_WIDTH-1 -: TAG_BITS];

  assign rd_index_o = in_index;  // Arrays read in the same cycle as the grant

  // --------------------------------------------------
  // Stage 1 register
  // --------------------------------------------------
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      s1_req_o <= 1'b0;
    end else if (clear_i) begin
      s1_req_o <= 1'b0;
    end else if (advance_i) begin
      s1_req_o <= fetch_req_i;
    end
  end

  always_ff @(posedge clk) begin
    if (advance_i) begin
      s1_id_o    <= fetch_id_i;
      s1_index_o <= in_index;
      s1_tag_o   <= in_tag;
      s1_word_o  <= in_word;
    end
  end

  // Hit needs both the stored valid bit and a matching tag
  assign s1_hit_o = tag_entry_i[TAG_BITS] && (tag_entry_i[TAG_BITS-1:0] == s1_tag_o);

endmodule

//--- rtl/icache_pkg.sv
/* Cache geometry constants, typed vectors for addresses, words, tags and lines,
   and the controller state encoding */

package icache_pkg;

  // --------------------------------------------------
  // Geometry
  // --------------------------------------------------
  localparam int ADDR_WIDTH    = 32;
  localparam int DATA_WIDTH    = 32;
  localparam int ID_WIDTH      = 4;
  localparam int LINE_WORDS    = 4;
  localparam int N_ROWS        = 64;

  // Address split: | tag | index | word | byte |
  localparam int OFFSET_BITS   = $clog2(DATA_WIDTH / 8);     // 2
  localparam int WORD_SEL_BITS = $clog2(LINE_WORDS);         // 2
  localparam int INDEX_BITS    = $clog2(N_ROWS);             // 6
  localparam int TAG_BITS      = ADDR_WIDTH - INDEX_BITS - WORD_SEL_BITS - OFFSET_BITS;
  localparam int LINE_WIDTH    = LINE_WORDS * DATA_WIDTH;    // 128

  // --------------------------------------------------
  // Vector types
  // --------------------------------------------------
  typedef logic [ADDR_WIDTH-1:0]    addr_t;
  typedef logic [DATA_WIDTH-1:0]    data_t;
  typedef logic [ID_WIDTH-1:0]      id_t;
  typedef logic [INDEX_BITS-1:0]    index_t;
  typedef logic [TAG_BITS-1:0]      tag_t;
  typedef logic [WORD_SEL_BITS-1:0] word_sel_t;
  typedef logic [LINE_WIDTH-1:0]    line_t;

  // Valid bit sits above the stored tag
  typedef logic [TAG_BITS:0]        tag_entry_t;

  // --------------------------------------------------
  // Controller states
  // --------------------------------------------------
  typedef enum logic [2:0] {
    DISABLED,     // No fetches granted, disable acknowledged
    INVALIDATE,   // One row cleared per cycle
    OPERATIVE,    // Lookup pipeline running
    REFILL_REQ,   // Line address offered to memory
    REFILL_WAIT,  // Waiting for the line
    DISPATCH      // Gap cycle after a refill
  } ctrl_state_t;

endpackage
